// ==== flist.f ====
+incdir+include
logic/acmd_pkg.sv
logic/acmd_encoder.sv
logic/acmd_word_fifo.sv
logic/acmd_pad_serializer.sv
logic/acmd_path_top.sv
verif/acmd_path_tb.sv

// ==== include/acmd_macros.svh ====
// Address/command path constants for pin layout, word packing and buffer depth
`ifndef ACMD_MACROS_SVH
`define ACMD_MACROS_SVH

// ******************************
// Pin and word geometry
// ******************************

// Pins from MSB down are cs_n, ras_n, cas_n, we_n, bank[2:0], addr[8:0]
`define ACMD_PIN_WIDTH 16

// One quarter-rate word carries four full-rate pin beats
`define ACMD_BEATS 4

// Beat 0 occupies the least significant pin slice of the word
`define ACMD_WORD_WIDTH (`ACMD_PIN_WIDTH * `ACMD_BEATS)

// Number of words the buffer between encoder and pad can hold
`define ACMD_FIFO_DEPTH 4

// Idle pin value, all control bits high with bank and address at zero
`define ACMD_DESELECT 16'hf000

`endif

// ==== logic/acmd_encoder.sv ====
// Command encoder that packs one DDR3 command plus three NOP beats into a quarter-rate word
`timescale 1ns/1ps

`include "acmd_macros.svh"

module acmd_encoder (
    input  logic                         leveling_clk,
    input  logic                         rst_n,
    input  logic                         cmd_req,
    input  acmd_pkg::cmd_opcode_e        cmd_opcode,
    input  logic [2:0]                   cmd_bank,
    input  logic [8:0]                   cmd_addr,
    input  logic                         word_full,
    output logic                         word_push,
    output logic [`ACMD_WORD_WIDTH-1:0]  word_data,
    output logic                         cmd_drop
);

    import acmd_pkg::*;

    // Control bits in pin order ras_n, cas_n, we_n
    logic [2:0]                   cmd_ctrl;
    logic [`ACMD_PIN_WIDTH-1:0]   cmd_beat;
    logic [`ACMD_PIN_WIDTH-1:0]   nop_beat;
    logic [`ACMD_WORD_WIDTH-1:0]  next_word;
    logic                         req_accept;

    // ******************************
    // Opcode to pin translation
    // ******************************

    always_comb begin
        case (cmd_opcode)
            CMD_NOP:       cmd_ctrl = 3'b111;
            CMD_ACTIVATE:  cmd_ctrl = 3'b011;
            CMD_READ:      cmd_ctrl = 3'b101;
            CMD_WRITE:     cmd_ctrl = 3'b100;
            CMD_PRECHARGE: cmd_ctrl = 3'b010;
            CMD_REFRESH:   cmd_ctrl = 3'b001;
            // Unused encodings fall back to a harmless NOP
            default:       cmd_ctrl = 3'b111;
        endcase
    end

    // Chip select is low for every command, including a requested NOP
    assign cmd_beat = {1'b0, cmd_ctrl, cmd_bank, cmd_addr};

    // Filler beats are NOPs with bank and address held at zero
    assign nop_beat = {1'b0, 3'b111, 3'b000, 9'd0};

    // The command lands in beat 0 and NOPs pad out the rest of the word
    always_comb begin
        next_word = '0;
        for (int b = 0; b < `ACMD_BEATS; b++) begin
            next_word[b*`ACMD_PIN_WIDTH +: `ACMD_PIN_WIDTH] = (b == 0) ? cmd_beat : nop_beat;
        end
    end

    // A request only goes forward when the buffer reports room for it
    assign req_accept = cmd_req && !word_full;

    // ******************************
    // Output registers
    // ******************************

    // Push and drop strobes follow the request by exactly one cycle
    always_ff @(posedge leveling_clk) begin
        if (!rst_n) begin
            word_push <= 1'b0;
            cmd_drop  <= 1'b0;
        end else begin
            word_push <= req_accept;
            cmd_drop  <= cmd_req && word_full;
        end
    end

    // Word payload is only loaded on an accepted request
    always_ff @(posedge leveling_clk) begin
        if (req_accept) begin
            word_data <= next_word;
        end
    end

endmodule

// ==== logic/acmd_pad_serializer.sv ====
// Pad serializer taking quarter-rate words through half rate and full rate onto the pins
`timescale 1ns/1ps

`include "acmd_macros.svh"

module acmd_pad_serializer (
    input  logic                         leveling_clk,
    input  logic                         rst_n,
    input  logic [`ACMD_WORD_WIDTH-1:0]  word_head,
    input  logic                         word_empty,
    output logic                         word_pop,
    output logic [`ACMD_PIN_WIDTH-1:0]   mem_ac
);

    import acmd_pkg::*;

    localparam int CNT_W  = $clog2(`ACMD_BEATS);
    localparam int HALF_W = `ACMD_WORD_WIDTH / 2;

    ser_state_e                   state;
    logic [CNT_W-1:0]             beat_cnt;
    logic                         last_beat;

    // Half-rate stage, the word taken from the buffer split into two half-words
    logic [`ACMD_WORD_WIDTH-1:0]  hr_word;
    logic [HALF_W-1:0]            hr_half_lo;
    logic [HALF_W-1:0]            hr_half_hi;

    // Full-rate stage, one half-word and then one beat out of it
    logic [HALF_W-1:0]            fr_half;
    logic [CNT_W-2:0]             fr_idx;
    logic [`ACMD_PIN_WIDTH-1:0]   fr_beat;

    assign last_beat = (beat_cnt == CNT_W'(`ACMD_BEATS - 1));

    // ******************************
    // Pop scheduling
    // ******************************

    // From IDLE the first waiting word is taken at once
    // In SHIFT the next word is taken while beat 3 is selected, so words
    // follow each other without a deselect gap
    always_comb begin
        word_pop = 1'b0;
        case (state)
            SER_IDLE:  word_pop = !word_empty;
            SER_SHIFT: word_pop = last_beat && !word_empty;
            default:   word_pop = 1'b0;
        endcase
    end

    always_ff @(posedge leveling_clk) begin
        if (!rst_n) begin
            state    <= SER_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                SER_IDLE: begin
                    beat_cnt <= '0;
                    if (word_pop) begin
                        state <= SER_SHIFT;
                    end
                end
                SER_SHIFT: begin
                    // Counter wraps to 0 on the last beat, ready for a chained word
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat && !word_pop) begin
                        state <= SER_IDLE;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // ******************************
    // Rate conversion datapath
    // ******************************

    // Half-rate register may already hold the next word while the pad
    // register is still showing the last beat of the current one
    always_ff @(posedge leveling_clk) begin
        if (word_pop) begin
            hr_word <= word_head;
        end
    end

    // Lower half carries beats 0 and 1, upper half beats 2 and 3
    assign hr_half_lo = hr_word[HALF_W-1:0];
    assign hr_half_hi = hr_word[`ACMD_WORD_WIDTH-1:HALF_W];

    // Top counter bit picks the half, the rest picks the beat inside it
    assign fr_half = beat_cnt[CNT_W-1] ? hr_half_hi : hr_half_lo;
    assign fr_idx  = beat_cnt[CNT_W-2:0];
    assign fr_beat = fr_half[fr_idx*`ACMD_PIN_WIDTH +: `ACMD_PIN_WIDTH];

    // Pad register, the last flop before the pins
    always_ff @(posedge leveling_clk) begin
        if (!rst_n) begin
            mem_ac <= `ACMD_DESELECT;
        end else if (state == SER_SHIFT) begin
            mem_ac <= fr_beat;
        end else begin
            mem_ac <= `ACMD_DESELECT;
        end
    end

endmodule

// ==== logic/acmd_path_top.sv ====
// Address/command output path joining the encoder, word FIFO and pad serializer
`timescale 1ns/1ps

`include "acmd_macros.svh"

module acmd_path_top (
    input  logic                        leveling_clk,
    input  logic                        rst_n,
    input  logic                        cmd_req,
    input  acmd_pkg::cmd_opcode_e       cmd_opcode,
    input  logic [2:0]                  cmd_bank,
    input  logic [8:0]                  cmd_addr,
    output logic                        cmd_full,
    output logic                        cmd_drop,
    output logic [`ACMD_PIN_WIDTH-1:0]  mem_ac
);

    // Encoder to buffer
    logic                         word_push;
    logic [`ACMD_WORD_WIDTH-1:0]  word_data;
    logic                         word_full;

    // Buffer to serializer
    logic                         word_pop;
    logic [`ACMD_WORD_WIDTH-1:0]  word_head;
    logic                         word_empty;

    // ******************************
    // Producer
    // ******************************

    acmd_encoder i_acmd_encoder (
        .leveling_clk (leveling_clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_opcode   (cmd_opcode),
        .cmd_bank     (cmd_bank),
        .cmd_addr     (cmd_addr),
        .word_full    (word_full),
        .word_push    (word_push),
        .word_data    (word_data),
        .cmd_drop     (cmd_drop)
    );

    acmd_word_fifo i_acmd_word_fifo (
        .leveling_clk (leveling_clk),
        .rst_n        (rst_n),
        .word_push    (word_push),
        .word_data    (word_data),
        .word_pop     (word_pop),
        .word_head    (word_head),
        .word_full    (word_full),
        .word_empty   (word_empty)
    );

    // ******************************
    // Consumer
    // ******************************

    acmd_pad_serializer i_acmd_pad_serializer (
        .leveling_clk (leveling_clk),
        .rst_n        (rst_n),
        .word_head    (word_head),
        .word_empty   (word_empty),
        .word_pop     (word_pop),
        .mem_ac       (mem_ac)
    );

    // Requesters see the buffer's full flag directly
    assign cmd_full = word_full;

endmodule

// ==== logic/acmd_pkg.sv ====
// Shared enum types for the address/command encoder and pad serializer
package acmd_pkg;

    // ******************************
    // Command opcodes
    // ******************************

    // Opcodes accepted on the request side of the encoder
    // The control pin pattern of each one follows the DDR3 truth table
    typedef enum logic [2:0] {
        CMD_NOP       = 3'd0,
        CMD_ACTIVATE  = 3'd1,
        CMD_READ      = 3'd2,
        CMD_WRITE     = 3'd3,
        CMD_PRECHARGE = 3'd4,
        CMD_REFRESH   = 3'd5
    } cmd_opcode_e;

    // ******************************
    // Serializer states
    // ******************************

    // IDLE drives the deselect pattern onto the pins
    // SHIFT walks through the four beats of the word held in the half-rate stage
    typedef enum logic {
        SER_IDLE  = 1'b0,
        SER_SHIFT = 1'b1
    } ser_state_e;

endpackage

// ==== logic/acmd_word_fifo.sv ====
// Circular word buffer between the command encoder and the pad serializer
`timescale 1ns/1ps

`include "acmd_macros.svh"

module acmd_word_fifo (
    input  logic                         leveling_clk,
    input  logic                         rst_n,
    input  logic                         word_push,
    input  logic [`ACMD_WORD_WIDTH-1:0]  word_data,
    input  logic                         word_pop,
    output logic [`ACMD_WORD_WIDTH-1:0]  word_head,
    output logic                         word_full,
    output logic                         word_empty
);

    localparam int PTR_W = $clog2(`ACMD_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`ACMD_FIFO_DEPTH + 1);

    logic [`ACMD_WORD_WIDTH-1:0]  fifo_mem [`ACMD_FIFO_DEPTH];
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [CNT_W-1:0]             count;
    logic                         full_now;
    logic                         do_push;
    logic                         do_pop;

    assign full_now   = (count == CNT_W'(`ACMD_FIFO_DEPTH));
    assign word_empty = (count == '0);

    // The encoder samples full one cycle before its push lands, so the flag
    // also rises when the last free slot is being filled right now
    assign word_full = full_now ||
                       ((count == CNT_W'(`ACMD_FIFO_DEPTH - 1)) && word_push && !word_pop);

    // Overflowing pushes and pops from an empty buffer are discarded
    assign do_push = word_push && !full_now;
    assign do_pop  = word_pop && !word_empty;

    // Head word is visible the cycle after it was written
    assign word_head = fifo_mem[rd_ptr];

    // ******************************
    // Pointers and occupancy
    // ******************************

    always_ff @(posedge leveling_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`ACMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`ACMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A push and a pop in the same cycle leave the count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge leveling_clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= word_data;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile the address/command path with Verilator and run its testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=acmd_path_sim
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f flist.f \
    --top-module acmd_path_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The testbench prints its verdict on a line of its own
if grep -qx "all tests passed" "$LOG_FILE"; then
    echo "simulation result: pass"
    exit 0
fi

echo "simulation result: fail"
exit 1

// ==== verif/acmd_path_tb.sv ====
// Testbench for the address/command path with a reference model and pin stream monitor
`timescale 1ns/1ps

`include "acmd_macros.svh"

module acmd_path_tb;

    import acmd_pkg::*;

    logic                        leveling_clk = 1'b0;
    logic                        rst_n;
    logic                        cmd_req;
    cmd_opcode_e                 cmd_opcode;
    logic [2:0]                  cmd_bank;
    logic [8:0]                  cmd_addr;
    logic                        cmd_full;
    logic                        cmd_drop;
    logic [`ACMD_PIN_WIDTH-1:0]  mem_ac;

    // Expected pin beats and command opcodes, in the order they must leave the pads
    logic [`ACMD_PIN_WIDTH-1:0]  exp_beat_q[$];
    cmd_opcode_e                 exp_op_q[$];

    int     seed = 32'h60b3;
    string  cur_test;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    int     beat_idx;
    int     gap_count;
    int     drop_count;
    logic   stream_started;
    logic   saw_full;

    acmd_path_top i_acmd_path_top (
        .leveling_clk (leveling_clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_opcode   (cmd_opcode),
        .cmd_bank     (cmd_bank),
        .cmd_addr     (cmd_addr),
        .cmd_full     (cmd_full),
        .cmd_drop     (cmd_drop),
        .mem_ac       (mem_ac)
    );

    // 20 ns clock period
    always #10 leveling_clk = ~leveling_clk;

    // ******************************
    // Reference model
    // ******************************

    // DDR3 truth table, chip select low, then ras_n cas_n we_n, bank and address
    // Beats 1 to 3 are NOPs with zero bank and address
    function automatic logic [`ACMD_WORD_WIDTH-1:0] ref_word(input cmd_opcode_e op,
                                                             input logic [2:0] bank,
                                                             input logic [8:0] addr);
        logic [2:0]                   ctrl;
        logic [`ACMD_WORD_WIDTH-1:0]  w;
        case (op)
            CMD_ACTIVATE:  ctrl = 3'b011;
            CMD_READ:      ctrl = 3'b101;
            CMD_WRITE:     ctrl = 3'b100;
            CMD_PRECHARGE: ctrl = 3'b010;
            CMD_REFRESH:   ctrl = 3'b001;
            default:       ctrl = 3'b111;
        endcase
        w = {`ACMD_BEATS{16'h7000}};
        w[`ACMD_PIN_WIDTH-1:0] = {1'b0, ctrl, bank, addr};
        return w;
    endfunction

    // Inverse of the truth table, used on the command beat seen at the pins
    function automatic cmd_opcode_e decode_opcode(input logic [`ACMD_PIN_WIDTH-1:0] pins);
        case (pins[14:12])
            3'b011:  return CMD_ACTIVATE;
            3'b101:  return CMD_READ;
            3'b100:  return CMD_WRITE;
            3'b010:  return CMD_PRECHARGE;
            3'b001:  return CMD_REFRESH;
            default: return CMD_NOP;
        endcase
    endfunction

    // ******************************
    // Compare tasks
    // ******************************

    task automatic check_pins(input string name, input logic [`ACMD_PIN_WIDTH-1:0] exp_val,
                              input logic [`ACMD_PIN_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("error %s: expected %h, actual %h", name, exp_val, act_val);
            test_errors++;
        end
    endtask

    task automatic check_opcode(input string name, input cmd_opcode_e exp_val,
                                input cmd_opcode_e act_val);
        if (act_val !== exp_val) begin
            $display("error %s: expected %s, actual %s", name, exp_val.name(), act_val.name());
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("error %s: expected %b, actual %b", name, exp_val, act_val);
            test_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", cur_test, msg);
        test_errors++;
    endtask

    // ******************************
    // Pin stream monitor
    // ******************************

    // Deselect is never a command or NOP beat, since those all drive cs_n low
    always @(posedge leveling_clk) begin
        if (!rst_n) begin
            beat_idx = 0;
        end else if (mem_ac == `ACMD_DESELECT) begin
            if (beat_idx != 0) begin
                report_problem("pins went to deselect in the middle of a word");
                beat_idx = 0;
            end
            if (stream_started && exp_beat_q.size() != 0) begin
                gap_count++;
            end
        end else if (exp_beat_q.size() == 0) begin
            report_problem($sformatf("unexpected beat %h on the pins", mem_ac));
        end else begin
            if (beat_idx == 0) begin
                check_opcode({cur_test, " opcode"}, exp_op_q.pop_front(), decode_opcode(mem_ac));
            end
            check_pins({cur_test, " beat"}, exp_beat_q.pop_front(), mem_ac);
            stream_started = 1'b1;
            beat_idx = (beat_idx + 1) % `ACMD_BEATS;
        end
    end

    // ******************************
    // Stimulus helpers
    // ******************************

    task automatic expect_command(input cmd_opcode_e op, input logic [2:0] bank,
                                  input logic [8:0] addr);
        logic [`ACMD_WORD_WIDTH-1:0] w;
        w = ref_word(op, bank, addr);
        for (int b = 0; b < `ACMD_BEATS; b++) begin
            exp_beat_q.push_back(w[b*`ACMD_PIN_WIDTH +: `ACMD_PIN_WIDTH]);
        end
        exp_op_q.push_back(op);
    endtask

    // Called on a falling edge, a request made while full must be dropped
    task automatic send_command(input cmd_opcode_e op, input logic [2:0] bank,
                                input logic [8:0] addr);
        logic will_drop;
        will_drop = cmd_full;
        if (will_drop) begin
            saw_full = 1'b1;
        end else begin
            expect_command(op, bank, addr);
        end
        cmd_req    = 1'b1;
        cmd_opcode = op;
        cmd_bank   = bank;
        cmd_addr   = addr;
        @(negedge leveling_clk);
        cmd_req = 1'b0;
        // Drop pulses as they appear on the port
        if (cmd_drop === 1'b1) begin
            drop_count++;
        end
        check_flag({cur_test, " drop"}, will_drop, cmd_drop);
    endtask

    task automatic send_random(input int max_gap);
        logic [31:0] r;
        logic [31:0] g;
        r = $random(seed);
        send_command(cmd_opcode_e'(3'(r % 32'd6)), r[2:0], r[11:3]);
        g = $random(seed);
        repeat (g % 32'(max_gap + 1)) @(negedge leveling_clk);
    endtask

    // Waits until every expected beat has left and the pins are idle again
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_beat_q.size() != 0 || mem_ac != `ACMD_DESELECT) && n < limit) begin
            @(negedge leveling_clk);
            n++;
        end
        if (exp_beat_q.size() != 0 || mem_ac != `ACMD_DESELECT) begin
            report_problem("timed out waiting for the pin stream to drain");
            exp_beat_q.delete();
            exp_op_q.delete();
        end
        repeat (2) @(negedge leveling_clk);
    endtask

    task automatic wait_first_beat(input int limit);
        int n;
        n = 0;
        while (mem_ac == `ACMD_DESELECT && n < limit) begin
            @(negedge leveling_clk);
            n++;
        end
        if (mem_ac == `ACMD_DESELECT) begin
            report_problem("timed out waiting for a beat on the pins");
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_errors    = 0;
        gap_count      = 0;
        drop_count     = 0;
        stream_started = 1'b0;
        saw_full       = 1'b0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        tests_run++;
    endtask

    // ******************************
    // Test sequence
    // ******************************

    initial begin
        logic [31:0] r;
        cmd_req      = 1'b0;
        cmd_opcode   = CMD_NOP;
        cmd_bank     = 3'd0;
        cmd_addr     = 9'd0;
        rst_n        = 1'b0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        start_test("reset");
        repeat (4) @(negedge leveling_clk);
        rst_n = 1'b1;
        @(negedge leveling_clk);

        check_pins("reset mem_ac", `ACMD_DESELECT, mem_ac);
        check_flag("reset cmd_full", 1'b0, cmd_full);
        check_flag("reset cmd_drop", 1'b0, cmd_drop);
        finish_test();

        // Every opcode alone, with the pins idle before and after
        start_test("single_opcodes");
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            send_command(cmd_opcode_e'(3'(i)), r[2:0], r[11:3]);
            wait_drain(40);
        end
        finish_test();

        start_test("random_gaps");
        for (int i = 0; i < 16; i++) begin
            send_random(7);
        end
        wait_drain(200);
        finish_test();

        // One request every fourth cycle matches the drain rate of the serializer
        start_test("back_to_back");
        for (int i = 0; i < 6; i++) begin
            send_random(0);
            repeat (3) @(negedge leveling_clk);
        end
        wait_drain(80);
        if (gap_count != 0) begin
            report_problem("deselect gap seen between consecutive words");
        end
        finish_test();

        start_test("burst_full");
        for (int i = 0; i < 14; i++) begin
            send_random(0);
        end
        check_flag("burst_full cmd_full seen", 1'b1, saw_full);
        check_flag("burst_full drops seen", 1'b1, drop_count != 0);
        wait_drain(200);
        finish_test();

        // Reset lands while the buffer is full and words are on the pins
        start_test("mid_reset");
        for (int i = 0; i < 8; i++) begin
            send_random(0);
        end
        wait_first_beat(20);
        @(negedge leveling_clk);
        check_flag("mid_reset cmd_full before reset", 1'b1, cmd_full);
        rst_n = 1'b0;
        exp_beat_q.delete();
        exp_op_q.delete();
        repeat (4) @(negedge leveling_clk);
        rst_n = 1'b1;
        @(negedge leveling_clk);
        check_pins("mid_reset mem_ac", `ACMD_DESELECT, mem_ac);
        check_flag("mid_reset cmd_full", 1'b0, cmd_full);
        for (int i = 0; i < 3; i++) begin
            send_random(2);
        end
        wait_drain(80);
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
